// ==== verilog/timer_params.svh ====
// ==========================================================
// address map and sizes shared by the timer peripheral.
// include in any file that decodes bus addresses.
// ==========================================================
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// byte address width of the processor bus.
`define BUS_ADDR_WIDTH 16

// number of timers; region n below this count is timer n.
`define TIMER_COUNT 2

// region field position and size inside the address.
`define REGION_LSB 4
`define REGION_WIDTH 4
`define IRQ_REGION 15

// word index inside a region, taken from address bits 3 and 2.
`define LOCAL_ADDRESS_WIDTH 2

`endif

// ==== verilog/bus_pkg.sv ====
// ==========================================================
// request and response types of the memory-mapped bus, and
// the byte-strobe merge used by every register write.
// ==========================================================
`include "timer_params.svh"

package bus_pkg;

    localparam int BYTES_PER_WORD = 4;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [`BUS_ADDR_WIDTH-1:0] address;
        word_t                      wdata;
        logic [BYTES_PER_WORD-1:0]  byte_en;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } bus_rsp_t;

    // replace each strobed byte of the old word by the new byte.
    function automatic word_t write_merge(word_t old_word, word_t new_word,
                                          logic [BYTES_PER_WORD-1:0] byte_en);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (byte_en[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== verilog/timer_pkg.sv ====
// ==========================================================
// register layout of the timer and the local register map
// of the timer and the interrupt controller.
// ==========================================================
`include "timer_params.svh"

package timer_pkg;

    // reserved bits are kept as written.
    typedef struct packed {
        logic [27:0] reserved;
        logic        event_flag;
        logic        irq_enable;
        logic        cyclic_mode;
        logic        count_enable;
    } control_reg_t;

    typedef enum logic [`LOCAL_ADDRESS_WIDTH-1:0] {
        TIMER_CONTROL     = 2'd0,
        TIMER_REFILL      = 2'd1,
        TIMER_COUNT_VALUE = 2'd2
    } timer_reg_e;

    typedef enum logic [`LOCAL_ADDRESS_WIDTH-1:0] {
        IRQ_PENDING = 2'd0,
        IRQ_MASK    = 2'd1
    } irq_reg_e;

endpackage

// ==== verilog/bus_decoder.sv ====
// ==========================================================
// splits the address space into regions, selects one target
// and returns its read data with a same-cycle ready.
// ==========================================================
`include "timer_params.svh"

module bus_decoder (
    input  bus_pkg::bus_req_t         req,
    input  bus_pkg::word_t            timer_rdata [`TIMER_COUNT],
    input  bus_pkg::word_t            irq_rdata,
    output logic [`TIMER_COUNT-1:0]   timer_sel,
    output logic                      irq_sel,
    output bus_pkg::bus_rsp_t         rsp
);

    import bus_pkg::*;

    logic [`REGION_WIDTH-1:0] region;
    word_t                    selected_rdata;

    assign region = req.address[`REGION_LSB +: `REGION_WIDTH];

    // ==========================================================
    // region decode
    // ==========================================================
    always_comb begin
        timer_sel = '0;
        for (int i = 0; i < `TIMER_COUNT; i++) begin
            if (req.valid && int'(region) == i) begin
                timer_sel[i] = 1'b1;
            end
        end
    end

    assign irq_sel = req.valid && (int'(region) == `IRQ_REGION);

    // ==========================================================
    // read data and response
    // ==========================================================
    // unmapped regions leave the read data at zero.
    always_comb begin
        selected_rdata = '0;
        for (int i = 0; i < `TIMER_COUNT; i++) begin
            if (timer_sel[i]) begin
                selected_rdata = timer_rdata[i];
            end
        end
        if (irq_sel) begin
            selected_rdata = irq_rdata;
        end
    end

    // no back-pressure: every valid request completes at once.
    assign rsp.ready = req.valid;
    assign rsp.rdata = selected_rdata;

endmodule

// ==== verilog/timer.sv ====
// ==========================================================
// one countdown timer with control, refill and count words.
// instantiate once per timer region behind the bus decoder.
// ==========================================================
`include "timer_params.svh"

module timer (
    input  logic              bus,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    input  logic              sel,
    output bus_pkg::word_t    rdata,
    output logic              timer_irq
);

    import bus_pkg::*;
    import timer_pkg::*;

    timer_reg_e   local_address;
    control_reg_t control_reg;
    word_t        refill_reg;
    word_t        count_reg;
    word_t        refill_next;
    logic         write_en;
    logic         expired;

    // word index from address bits 3 and 2.
    assign local_address = timer_reg_e'(req.address[2 +: `LOCAL_ADDRESS_WIDTH]);
    assign write_en      = req.valid && req.write && sel;
    assign expired       = control_reg.count_enable && (count_reg == '0);
    assign refill_next   = write_merge(refill_reg, req.wdata, req.byte_en);

    // ==========================================================
    // control register
    // ==========================================================
    // a bus write wins over the event update in the same cycle.
    always_ff @(posedge bus) begin
        if (rst) begin
            control_reg <= '0;
        end else if (write_en && local_address == TIMER_CONTROL) begin
            control_reg <= control_reg_t'(write_merge(word_t'(control_reg),
                                                      req.wdata, req.byte_en));
        end else if (expired) begin
            control_reg.event_flag <= 1'b1;
            // one-shot mode stops after the first event.
            if (!control_reg.cyclic_mode) begin
                control_reg.count_enable <= 1'b0;
            end
        end
    end

    // ==========================================================
    // refill and count registers
    // ==========================================================
    always_ff @(posedge bus) begin
        if (rst) begin
            refill_reg <= '0;
            count_reg  <= '0;
        end else if (write_en && local_address == TIMER_REFILL) begin
            refill_reg <= refill_next;
            count_reg  <= refill_next;
        end else if (control_reg.count_enable && count_reg != '0) begin
            count_reg <= count_reg - 1'b1;
        end else begin
            // reload at zero, track refill while stopped.
            count_reg <= refill_reg;
        end
    end

    // local address 3 also returns the count.
    always_comb begin
        case (local_address)
            TIMER_CONTROL: rdata = word_t'(control_reg);
            TIMER_REFILL:  rdata = refill_reg;
            default:       rdata = count_reg;
        endcase
    end

    assign timer_irq = control_reg.event_flag && control_reg.irq_enable;

endmodule

// ==== verilog/irq_controller.sv ====
// ==========================================================
// collects the timer interrupt lines into a sticky pending
// register and masks them onto one interrupt output.
// ==========================================================
`include "timer_params.svh"

module irq_controller (
    input  logic                    bus,
    input  logic                    rst,
    input  bus_pkg::bus_req_t       req,
    input  logic                    sel,
    input  logic [`TIMER_COUNT-1:0] timer_irq,
    output bus_pkg::word_t          rdata,
    output logic                    irq
);

    import bus_pkg::*;
    import timer_pkg::*;

    irq_reg_e                local_address;
    logic [`TIMER_COUNT-1:0] timer_irq_d;
    logic [`TIMER_COUNT-1:0] rising;
    logic [`TIMER_COUNT-1:0] pending;
    logic [`TIMER_COUNT-1:0] mask;
    logic [`TIMER_COUNT-1:0] clear;
    word_t                   clear_word;
    word_t                   mask_next;
    logic                    write_en;

    assign local_address = irq_reg_e'(req.address[2 +: `LOCAL_ADDRESS_WIDTH]);
    assign write_en      = req.valid && req.write && sel;
    assign rising        = timer_irq & ~timer_irq_d;

    // only strobed bytes can clear pending bits.
    assign clear_word = write_merge('0, req.wdata, req.byte_en);
    assign clear      = (write_en && local_address == IRQ_PENDING) ?
                        clear_word[`TIMER_COUNT-1:0] : '0;
    assign mask_next  = write_merge(word_t'(mask), req.wdata, req.byte_en);

    always_ff @(posedge bus) begin
        if (rst) begin
            timer_irq_d <= '0;
            pending     <= '0;
            mask        <= '0;
        end else begin
            timer_irq_d <= timer_irq;
            // a new edge beats a clear in the same cycle.
            pending <= (pending & ~clear) | rising;
            if (write_en && local_address == IRQ_MASK) begin
                mask <= mask_next[`TIMER_COUNT-1:0];
            end
        end
    end

    always_comb begin
        case (local_address)
            IRQ_PENDING: rdata = word_t'(pending);
            IRQ_MASK:    rdata = word_t'(mask);
            default:     rdata = '0;
        endcase
    end

    assign irq = |(pending & mask);

endmodule

// ==== verilog/timer_subsystem.sv ====
// ==========================================================
// timer peripheral top level: address decoder, a bank of
// timers and the interrupt controller on one bus port.
// ==========================================================
`include "timer_params.svh"

module timer_subsystem (
    input  logic              bus,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp,
    output logic              irq
);

    import bus_pkg::*;

    logic [`TIMER_COUNT-1:0] timer_sel;
    logic [`TIMER_COUNT-1:0] timer_irq;
    logic                    irq_sel;
    word_t                   timer_rdata [`TIMER_COUNT];
    word_t                   irq_rdata;

    bus_decoder bus_decoder_i (
        .req         (req),
        .timer_rdata (timer_rdata),
        .irq_rdata   (irq_rdata),
        .timer_sel   (timer_sel),
        .irq_sel     (irq_sel),
        .rsp         (rsp)
    );

    // one timer per region, starting at region 0.
    for (genvar i = 0; i < `TIMER_COUNT; i++) begin : g_timer
        timer timer_i (
            .bus       (bus),
            .rst       (rst),
            .req       (req),
            .sel       (timer_sel[i]),
            .rdata     (timer_rdata[i]),
            .timer_irq (timer_irq[i])
        );
    end

    irq_controller irq_controller_i (
        .bus       (bus),
        .rst       (rst),
        .req       (req),
        .sel       (irq_sel),
        .timer_irq (timer_irq),
        .rdata     (irq_rdata),
        .irq       (irq)
    );

endmodule

// ==== tb/timer_subsystem_checker.sv ====
// ==========================================================
// concurrent checks on the timer peripheral ports, bound to
// the top level from the testbench.
// ==========================================================
`include "timer_params.svh"

module timer_subsystem_checker (
    input logic              bus,
    input logic              rst,
    input bus_pkg::bus_req_t req,
    input bus_pkg::bus_rsp_t rsp,
    input logic              irq
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [`REGION_WIDTH-1:0] region;
    logic                     unmapped;

    assign region   = req.address[`REGION_LSB +: `REGION_WIDTH];
    assign unmapped = (int'(region) >= `TIMER_COUNT) && (int'(region) != `IRQ_REGION);

    ready_follows_valid: assert property (@(posedge bus) rsp.ready == req.valid)
        else $error("ready does not follow valid");

    unmapped_reads_zero: assert property (@(posedge bus) disable iff (rst)
        (req.valid && !req.write && unmapped) |-> rsp.rdata == '0)
        else $error("unmapped read returned nonzero data");

    irq_low_after_reset: assert property (@(posedge bus) rst |=> !irq)
        else $error("irq high in the cycle after reset");

endmodule

// ==== tb/timer_subsystem_tb.sv ====
// ==========================================================
// testbench for the timer peripheral: drives the bus, models
// the registers and checks reads, periods and interrupts.
// ==========================================================
`include "timer_params.svh"

module timer_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import bus_pkg::*;
    import timer_pkg::*;

    typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;

    localparam int    MAX_REFILL  = 40;
    localparam int    ROUNDS      = 6;
    localparam int    EVENTS      = 4;
    localparam word_t MASK_BITS   = word_t'((1 << `TIMER_COUNT) - 1);
    // two cycles per transfer, plus each refill wait times its repeat count.
    localparam int    CYCLE_LIMIT = 8 + 2 * (ROUNDS * 11 + 60)
                                  + (MAX_REFILL + 2) * (2 + EVENTS) + 200;

    logic     bus;
    logic     rst;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     irq;
    logic     irq_d;
    logic     irq_seen;
    logic     compare_en;
    string    compare_name;
    word_t    compare_expected;
    word_t    read_value;
    int       cycle_count;
    int       rise_cycles [$];

    timer_subsystem timer_subsystem_i (
        .bus (bus), .rst (rst), .req (req), .rsp (rsp), .irq (irq)
    );

    bind timer_subsystem timer_subsystem_checker checker_i (
        .bus (bus), .rst (rst), .req (req), .rsp (rsp), .irq (irq)
    );

    always #20 bus = ~bus;

    // ==========================================================
    // reference model and checking
    // ==========================================================
    function automatic word_t expected_merge(word_t old_word, word_t new_word,
                                             logic [3:0] strobes);
        word_t byte_mask;
        byte_mask = {{8{strobes[3]}}, {8{strobes[2]}}, {8{strobes[1]}}, {8{strobes[0]}}};
        return (old_word & ~byte_mask) | (new_word & byte_mask);
    endfunction

    // a cyclic timer fires once per refill+1 cycles.
    function automatic int expected_period(word_t refill);
        return int'(refill) + 1;
    endfunction

    function automatic addr_t reg_address(int region, logic [1:0] word_index);
        return addr_t'((region << `REGION_LSB) | (int'(word_index) << 2));
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // samples every read on the rising edge and checks it when asked.
    always @(posedge bus) begin
        if (req.valid && !req.write) begin
            read_value = rsp.rdata;
            if (compare_en) begin
                check_value(compare_name, compare_expected, rsp.rdata);
            end
        end
    end

    // cycle count, irq rise times and the run limit.
    always @(posedge bus) begin
        cycle_count++;
        if (irq && !irq_d) begin
            rise_cycles.push_back(cycle_count);
        end
        irq_seen = irq_seen | irq;
        irq_d    = irq;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Errors found");
            $fatal(1, "timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    // ==========================================================
    // bus tasks
    // ==========================================================
    // one transfer cycle, then one idle cycle.
    task automatic transfer(logic write, addr_t address, word_t wdata, logic [3:0] byte_en);
        @(negedge bus);
        req = '{valid: 1'b1, write: write, address: address, wdata: wdata, byte_en: byte_en};
        @(negedge bus);
        req.valid  = 1'b0;
        compare_en = 1'b0;
    endtask

    task automatic bus_write(addr_t address, word_t wdata, logic [3:0] byte_en);
        transfer(1'b1, address, wdata, byte_en);
    endtask

    task automatic bus_read(addr_t address, output word_t data);
        transfer(1'b0, address, '0, 4'hf);
        data = read_value;
    endtask

    task automatic read_check(string name, addr_t address, word_t expected);
        compare_name     = name;
        compare_expected = expected;
        compare_en       = 1'b1;
        transfer(1'b0, address, '0, 4'hf);
    endtask

    // ==========================================================
    // tests
    // ==========================================================
    initial begin
        word_t      data;
        word_t      wdata;
        word_t      refill;
        word_t      mask_model;
        word_t      refill_model [`TIMER_COUNT];
        word_t      control_model [`TIMER_COUNT];
        logic [3:0] strobes;
        int         region;
        void'($urandom(32'h5f8b_9271));
        bus         = 1'b0;
        rst         = 1'b1;
        req         = '0;
        irq_d       = 1'b0;
        irq_seen    = 1'b0;
        compare_en  = 1'b0;
        cycle_count = 0;
        mask_model  = '0;
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            refill_model[t]  = '0;
            control_model[t] = '0;
        end
        repeat (8) @(posedge bus);
        @(negedge bus);
        rst = 1'b0;

        // strobed register writes; count enable stays off.
        for (int round = 0; round < ROUNDS; round++) begin
            for (int t = 0; t < `TIMER_COUNT; t++) begin
                wdata   = $urandom;
                strobes = 4'($urandom);
                refill_model[t] = expected_merge(refill_model[t], wdata, strobes);
                bus_write(reg_address(t, TIMER_REFILL), wdata, strobes);
                read_check("refill access", reg_address(t, TIMER_REFILL), refill_model[t]);
                wdata   = $urandom & ~32'h1;
                strobes = 4'($urandom);
                control_model[t] = expected_merge(control_model[t], wdata, strobes);
                bus_write(reg_address(t, TIMER_CONTROL), wdata, strobes);
                read_check("control access", reg_address(t, TIMER_CONTROL), control_model[t]);
            end
            wdata      = $urandom;
            strobes    = 4'($urandom);
            mask_model = expected_merge(mask_model, wdata, strobes) & MASK_BITS;
            bus_write(reg_address(`IRQ_REGION, IRQ_MASK), wdata, strobes);
            read_check("mask access", reg_address(`IRQ_REGION, IRQ_MASK), mask_model);
            region = `TIMER_COUNT + int'($urandom % (`IRQ_REGION - `TIMER_COUNT));
            read_check("unmapped read", reg_address(region, 2'($urandom)), '0);
        end
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            bus_write(reg_address(t, TIMER_CONTROL), '0, 4'hf);
        end
        bus_write(reg_address(`IRQ_REGION, IRQ_PENDING), MASK_BITS, 4'hf);
        bus_write(reg_address(`IRQ_REGION, IRQ_MASK), MASK_BITS, 4'hf);

        // one-shot on timer 0 with interrupts off and the mask open.
        refill   = word_t'(3 + $urandom % 38);
        irq_seen = 1'b0;
        bus_write(reg_address(0, TIMER_REFILL), refill, 4'hf);
        bus_write(reg_address(0, TIMER_CONTROL), 32'h1, 4'hf);
        do begin
            bus_read(reg_address(0, TIMER_CONTROL), data);
        end while (!data[3]);
        check_value("one-shot stop", 32'h8, data);
        read_check("one-shot reload", reg_address(0, TIMER_COUNT_VALUE), refill);
        check_value("one-shot irq", '0, word_t'(irq_seen));
        bus_write(reg_address(0, TIMER_CONTROL), '0, 4'hf);

        // cyclic period on timer 0, measured between irq rises.
        refill = word_t'(20 + $urandom % 21);
        bus_write(reg_address(`IRQ_REGION, IRQ_MASK), 32'h1, 4'hf);
        bus_write(reg_address(0, TIMER_REFILL), refill, 4'hf);
        rise_cycles.delete();
        bus_write(reg_address(0, TIMER_CONTROL), 32'h7, 4'hf);
        for (int k = 0; k < EVENTS; k++) begin
            while (rise_cycles.size() <= k) @(negedge bus);
            bus_write(reg_address(0, TIMER_CONTROL), 32'h7, 4'hf);
            bus_write(reg_address(`IRQ_REGION, IRQ_PENDING), 32'h1, 4'hf);
        end
        bus_write(reg_address(0, TIMER_CONTROL), '0, 4'hf);
        for (int k = 1; k < EVENTS; k++) begin
            check_value("cyclic period", word_t'(expected_period(refill)),
                        word_t'(rise_cycles[k] - rise_cycles[k-1]));
        end

        // both timers fire once; mask and clear the pending bits.
        bus_write(reg_address(`IRQ_REGION, IRQ_PENDING), MASK_BITS, 4'hf);
        bus_write(reg_address(`IRQ_REGION, IRQ_MASK), MASK_BITS, 4'hf);
        for (int t = 0; t < 2; t++) begin
            bus_write(reg_address(t, TIMER_REFILL), word_t'(3 + $urandom % 38), 4'hf);
            bus_write(reg_address(t, TIMER_CONTROL), 32'h5, 4'hf);
        end
        do begin
            bus_read(reg_address(`IRQ_REGION, IRQ_PENDING), data);
        end while (data[1:0] != 2'b11);
        read_check("pending both", reg_address(`IRQ_REGION, IRQ_PENDING), 32'h3);
        bus_write(reg_address(`IRQ_REGION, IRQ_MASK), 32'h2, 4'hf);
        check_value("irq from timer 1", 32'h1, word_t'(irq));
        bus_write(reg_address(`IRQ_REGION, IRQ_PENDING), 32'h2, 4'hf);
        check_value("irq after clear", '0, word_t'(irq));
        repeat (4) @(negedge bus);
        read_check("pending stays clear", reg_address(`IRQ_REGION, IRQ_PENDING), 32'h1);
        bus_write(reg_address(`IRQ_REGION, IRQ_MASK), 32'h1, 4'hf);
        check_value("irq from timer 0", 32'h1, word_t'(irq));
        bus_write(reg_address(`IRQ_REGION, IRQ_PENDING), 32'h1, 4'hf);
        read_check("pending cleared", reg_address(`IRQ_REGION, IRQ_PENDING), '0);
        bus_write(reg_address(0, TIMER_CONTROL), '0, 4'hf);
        bus_write(reg_address(1, TIMER_CONTROL), '0, 4'hf);

        // stopped counter follows refill.
        refill = word_t'(3 + $urandom % 38);
        bus_write(reg_address(1, TIMER_REFILL), refill, 4'hf);
        read_check("stopped count", reg_address(1, TIMER_COUNT_VALUE), refill);
        refill = word_t'(3 + $urandom % 38);
        bus_write(reg_address(1, TIMER_REFILL), refill, 4'hf);
        read_check("new refill count", reg_address(1, 2'd3), refill);

        $display("No errors");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/timer_pkg.sv
verilog/bus_decoder.sv
verilog/timer.sv
verilog/irq_controller.sv
verilog/timer_subsystem.sv
tb/timer_subsystem_checker.sv
tb/timer_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the timer peripheral testbench with Verilator and runs it.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module timer_subsystem_tb \
    --Mdir obj_dir -o timer_sim &&
./obj_dir/timer_sim ||
{ echo "simulation failed"; exit 1; }
